/* files.f */
uart_cmd_pkg.sv
byte_link_if.sv
uart_rx.sv
uart_tx.sv
uart_cmd_parser.sv
uart_cmd_top.sv
uart_cmd_properties.sv
uart_cmd_tb.sv

/* Bender.yml */
package:
  name: uart_cmd

sources:
  - uart_cmd_pkg.sv
  - byte_link_if.sv
  - uart_rx.sv
  - uart_tx.sv
  - uart_cmd_parser.sv
  - uart_cmd_top.sv
  - target: test
    files:
      - uart_cmd_properties.sv
      - uart_cmd_tb.sv

/* uart_cmd_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_tb;
    import uart_cmd_pkg::*;

    // what one frame should produce
    typedef struct packed {
        logic        strobe;
        logic [15:0] addr;
        logic [15:0] data;
        logic [7:0]  status;
    } expect_t;

    localparam int NUM_RANDOM = 20;
    localparam int NUM_FRAMES = NUM_RANDOM + 4;                // four directed frames
    localparam int GAP_BITS   = 5;                             // random gaps of 0 to 31 cycles
    localparam int IDLE_GAP   = WATCHDOG_CYCLES + 4 * CLKS_PER_BIT;
    // rx bytes plus status bytes, random gaps, watchdog silence, then 20 percent margin
    localparam int RUN_CYCLES = ((NUM_FRAMES * FRAME_BYTES + 3 + NUM_FRAMES) * 10 * CLKS_PER_BIT
                                + NUM_RANDOM * FRAME_BYTES * 31 + IDLE_GAP) * 12 / 10;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        rx = 1'b1;                                    // line idles high
    logic        tx;
    logic [15:0] wr_addr;
    logic [15:0] wr_data;
    logic        wr_en;
    logic [7:0]  led;
    logic [31:0] lfsr = 32'h065c7065;
    expect_t     exp_write_q[$];                               // good frames only
    logic [7:0]  exp_status_q[$];
    logic [7:0]  got_status_q[$];                              // filled by the tx monitor
    logic [15:0] last_addr = '0;
    logic [15:0] last_data = '0;
    int          exp_strobes = 0;
    int          strobe_count = 0;
    int          cycle_cnt = 0;

    uart_cmd_top dut0 (.*);

    always #20 clk = ~clk;  // 40 ns period

    // ========================================
    // helpers
    // ========================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};      // taps 32 22 2 1
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;  // drive just after the edge
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] bits;
        bits = {1'b1, b, 1'b0};                                // stop, data, start
        for (int i = 0; i < 10; i++) begin
            rx = bits[i];
            wait_cycles(CLKS_PER_BIT);
        end
    endtask

    function automatic frame_u make_frame(input logic [7:0] cmd, input logic [15:0] addr,
                                          input logic [15:0] data, input logic [23:0] trailer);
        frame_u f;
        f.bytes[7] = cmd;                                      // first on the wire
        {f.bytes[6], f.bytes[5]} = addr;
        {f.bytes[4], f.bytes[3]} = data;
        {f.bytes[2], f.bytes[1], f.bytes[0]} = trailer;
        return f;
    endfunction

    // expected write and status answer for one frame, in wire byte order
    function automatic expect_t ref_result(input frame_u f);
        expect_t e;
        e.strobe = (f.bytes[7] == CMD_WRITE) &&
                   ({f.bytes[2], f.bytes[1], f.bytes[0]} == END_MARKER);
        e.addr   = {f.bytes[6], f.bytes[5]};
        e.data   = {f.bytes[4], f.bytes[3]};
        e.status = e.strobe ? ACK_BYTE : NAK_BYTE;
        return e;
    endfunction

    task automatic stop_on_error();
        $display("Finished with errors");
        $fatal(1, "run stopped after a failure");
    endtask

    task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    // queue expectations, send the bytes, then check the held outputs
    task automatic send_frame(input frame_u f, input int gap_bits);
        expect_t     e;
        logic [31:0] gap;
        e = ref_result(f);
        if (e.strobe) begin
            exp_write_q.push_back(e);
            exp_strobes++;
            last_addr = e.addr;
            last_data = e.data;
        end
        exp_status_q.push_back(e.status);
        for (int i = FRAME_BYTES - 1; i >= 0; i--) begin
            take_bits(gap_bits, gap);
            wait_cycles(gap);
            send_byte(f.bytes[i]);
        end
        check_byte("led", ~f.bytes[0], led);                   // inverted trailer tail
        check_word("wr_addr", last_addr, wr_addr);             // unchanged after a nak
        check_word("wr_data", last_data, wr_data);
    endtask

    // ========================================
    // stimulus
    // ========================================
    initial begin : stimulus
        frame_u      f;
        logic [31:0] r;
        wait_cycles(10);
        reset = 1'b0;
        wait_cycles(4);
        check_byte("led", 8'hff, led);
        send_frame(make_frame(CMD_WRITE, 16'h1234, 16'hbeef, END_MARKER), 0);
        send_frame(make_frame(CMD_WRITE, 16'h5678, 16'hcafe, END_MARKER ^ 24'h1), 0);
        send_frame(make_frame(8'h52, 16'h9abc, 16'h0f0f, END_MARKER), 0);  // R, not a write
        send_byte(CMD_WRITE);                                  // partial frame
        send_byte(8'h00);
        send_byte(8'h40);
        wait_cycles(IDLE_GAP);                                 // watchdog drops it
        send_frame(make_frame(CMD_WRITE, 16'h0040, 16'h1357, END_MARKER), 0);
        repeat (NUM_RANDOM) begin
            take_bits(32, r);
            f = make_frame(CMD_WRITE, r[31:16], r[15:0], END_MARKER);
            take_bits(2, r);
            if (r[1:0] == 2'b00) begin                         // one in four
                take_bits(8, r);
                f.bytes[0] = f.bytes[0] ^ (r[7:0] | 8'h01);
            end
            send_frame(f, GAP_BITS);
        end
        while (exp_status_q.size() != 0) wait_cycles(1);
        wait_cycles(4 * CLKS_PER_BIT);
        check_count("wr_en pulses", exp_strobes, strobe_count);
        if (exp_write_q.size() != 0 || got_status_q.size() != 0) begin
            $display("missing write strobes or extra status bytes at the end of the run");
            stop_on_error();
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

    // ========================================
    // tx monitor, compare, timeout
    // ========================================
    initial begin : tx_monitor
        logic [7:0] b;
        forever begin
            @(negedge clk);
            if (!reset && tx === 1'b0) begin
                repeat (CLKS_PER_BIT / 2) @(negedge clk);      // middle of start bit
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    b[i] = tx;
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                if (tx !== 1'b1) begin
                    $display("tx stop bit was low at %0t", $time);
                    stop_on_error();
                end else begin
                    got_status_q.push_back(b);
                end
            end
        end
    end

    always @(negedge clk) begin : compare
        expect_t e;
        if (!reset && wr_en) begin
            if (exp_write_q.size() == 0) begin
                $display("wr_en pulsed at %0t but no write was expected", $time);
                stop_on_error();
            end else begin
                e = exp_write_q.pop_front();
                check_word("wr_addr", e.addr, wr_addr);
                check_word("wr_data", e.data, wr_data);
                strobe_count++;
            end
        end
        if (got_status_q.size() != 0) begin
            if (exp_status_q.size() == 0) begin
                $display("status byte %h arrived with no frame sent", got_status_q[0]);
                stop_on_error();
            end else begin
                check_byte("tx status", exp_status_q.pop_front(), got_status_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > RUN_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", RUN_CYCLES);
            stop_on_error();
        end
    end
endmodule

`default_nettype wire

/* uart_cmd_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_properties (
    input logic clk,
    input logic reset,
    input logic tx,
    input logic wr_en,
    input logic rx_valid,
    input logic tx_valid,
    input logic tx_busy
);
    // ========================================
    // strobes and handshake
    // ========================================
    a_wr_en_single: assert property (@(posedge clk) disable iff (reset) wr_en |=> !wr_en)
        else $error("wr_en high for two cycles in a row");

    a_rx_valid_single: assert property (@(posedge clk) disable iff (reset) rx_valid |=> !rx_valid)
        else $error("rx_valid high for two cycles in a row");

    // parser holds off while busy and the transmitter takes the byte at once
    a_tx_handshake: assert property (@(posedge clk) disable iff (reset)
        tx_valid |-> !tx_busy ##1 (tx_busy && !tx_valid))
        else $error("tx_valid raised while tx_busy or the byte was not accepted");

    a_tx_idle_reset: assert property (@(posedge clk) $past(reset) |-> tx)  // and one cycle after
        else $error("tx line not idle around reset");
endmodule

bind uart_cmd_top uart_cmd_properties props0 (
    .clk      (clk),
    .reset    (reset),
    .tx       (tx),
    .wr_en    (wr_en),
    .rx_valid (link.rx_valid),
    .tx_valid (link.tx_valid),
    .tx_busy  (link.tx_busy)
);

`default_nettype wire

/* uart_cmd_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_top (
    input  logic        clk,
    input  logic        reset,
    input  logic        rx,       // from host
    output logic        tx,       // to host
    output logic [15:0] wr_addr,
    output logic [15:0] wr_data,
    output logic        wr_en,
    output logic [7:0]  led       // inverted last rx byte
);

    // ========================================
    // byte link shared by all three blocks
    // ========================================
    byte_link_if link ();

    uart_rx u_rx (
        .clk   (clk),
        .reset (reset),
        .rx    (rx),
        .link  (link.rx_side)
    );

    uart_tx u_tx (
        .clk   (clk),
        .reset (reset),
        .tx    (tx),
        .link  (link.tx_side)
    );

    // frame decode, write strobe, ack or nak
    uart_cmd_parser u_parser (
        .clk     (clk),
        .reset   (reset),
        .link    (link.parser),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr_en   (wr_en),
        .led     (led)
    );
endmodule

`default_nettype wire

/* uart_cmd_parser.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_parser (
    input  logic         clk,
    input  logic         reset,
    byte_link_if.parser  link,
    output logic [15:0]  wr_addr,
    output logic [15:0]  wr_data,
    output logic         wr_en,
    output logic [7:0]   led
);
    import uart_cmd_pkg::*;

    frame_u                frame;           // bytes collected so far
    frame_u                frame_next;      // frame with the incoming byte appended
    logic [BYTE_CNT_W-1:0] byte_cnt;
    logic [WD_W-1:0]       wd_cnt;          // idle cycles inside a frame
    logic                  last_byte;
    logic                  frame_ok;
    logic                  status_pending;
    logic [7:0]            status_byte;

    // ========================================
    // frame assembly and checks
    // ========================================
    always_comb begin
        frame_next.bytes = {frame.bytes[FRAME_BYTES-2:0], link.rx_data};
    end

    assign last_byte = link.rx_valid && (byte_cnt == FRAME_BYTES - 1);
    assign frame_ok  = (frame_next.fields.cmd == CMD_WRITE) &&
                       (frame_next.fields.trailer == END_MARKER);

    // status byte offered only while the transmitter is free
    assign link.tx_valid = status_pending && !link.tx_busy;
    assign link.tx_data  = status_byte;

    always_ff @(posedge clk) begin
        if (link.rx_valid) frame <= frame_next;  // payload, shifted msb first
    end

    // byte counter and watchdog
    always_ff @(posedge clk) begin
        if (reset) begin
            byte_cnt <= '0;
            wd_cnt   <= '0;
        end else if (link.rx_valid) begin
            wd_cnt   <= '0;
            byte_cnt <= last_byte ? '0 : byte_cnt + 1'b1;  // wraps at frame end
        end else if (byte_cnt != '0) begin
            if (wd_cnt == WATCHDOG_CYCLES - 1) begin
                byte_cnt <= '0;  // drop partial frame silently
                wd_cnt   <= '0;
            end else begin
                wd_cnt <= wd_cnt + 1'b1;
            end
        end else begin
            wd_cnt <= '0;
        end
    end

    // ========================================
    // write strobe and status byte
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_en          <= 1'b0;
            wr_addr        <= '0;
            wr_data        <= '0;
            status_pending <= 1'b0;
            status_byte    <= ACK_BYTE;
        end else begin
            wr_en <= 1'b0;
            if (last_byte) begin
                status_pending <= 1'b1;
                status_byte    <= frame_ok ? ACK_BYTE : NAK_BYTE;
                if (frame_ok) begin
                    wr_en   <= 1'b1;                      // one cycle only
                    wr_addr <= frame_next.fields.addr;
                    wr_data <= frame_next.fields.data;
                end
            end else if (link.tx_valid) begin
                status_pending <= 1'b0;  // taken by the transmitter
            end
        end
    end

    // debug leds, active low on the board
    always_ff @(posedge clk) begin
        if (reset) begin
            led <= 8'hff;
        end else if (link.rx_valid) begin
            led <= ~link.rx_data;
        end
    end
endmodule

`default_nettype wire

/* uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic         clk,
    input  logic         reset,
    output logic         tx,
    byte_link_if.tx_side link
);
    import uart_cmd_pkg::*;

    logic [UART_FRAME_BITS-1:0] shift_frame;  // bit 0 is on the line
    logic [CNT_W-1:0]           clk_cnt;
    logic [3:0]                 bit_cnt;      // bits already finished

    assign tx = shift_frame[0];  // straight from a flop, no glitches

    // ========================================
    // load and shift
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            shift_frame  <= '1;  // line idles high
            clk_cnt      <= '0;
            bit_cnt      <= '0;
            link.tx_busy <= 1'b0;
        end else if (!link.tx_busy) begin
            if (link.tx_valid) begin
                // stop, data lsb first, start
                shift_frame  <= {1'b1, link.tx_data, 1'b0};
                link.tx_busy <= 1'b1;
                clk_cnt      <= '0;
                bit_cnt      <= '0;
            end
        end else if (clk_cnt == CLKS_PER_BIT - 1) begin
            clk_cnt     <= '0;
            shift_frame <= {1'b1, shift_frame[UART_FRAME_BITS-1:1]};  // fill with idle
            if (bit_cnt == UART_FRAME_BITS - 1) begin
                link.tx_busy <= 1'b0;  // end of stop bit
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end
endmodule

`default_nettype wire

/* uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic         clk,
    input  logic         reset,
    input  logic         rx,
    byte_link_if.rx_side link
);
    import uart_cmd_pkg::*;

    logic             rx_meta;     // first sync stage
    logic             rx_sync;     // safe to use
    logic [1:0]       state;
    logic [CNT_W-1:0] clk_cnt;     // position inside a bit
    logic [2:0]       bit_idx;
    logic [7:0]       data_sr;     // lsb arrives first

    assign link.rx_data = data_sr;

    // ========================================
    // two-flop synchronizer, idles high
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // ========================================
    // bit fsm
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= RX_IDLE;
            clk_cnt       <= '0;
            bit_idx       <= '0;
            link.rx_valid <= 1'b0;
        end else begin
            link.rx_valid <= 1'b0;  // pulse by default off
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (!rx_sync) state <= RX_START;  // falling start edge
                end
                RX_START: begin
                    if (clk_cnt == CLKS_PER_BIT / 2 - 1) begin
                        clk_cnt <= '0;
                        // glitch shorter than half a bit goes back to idle
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == CLKS_PER_BIT - 1) begin  // bit centre
                        clk_cnt <= '0;
                        data_sr <= {rx_sync, data_sr[7:1]};
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= RX_STOP;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (clk_cnt == CLKS_PER_BIT - 1) begin
                        clk_cnt       <= '0;
                        state         <= RX_IDLE;
                        link.rx_valid <= rx_sync;  // framing error drops the byte
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end
endmodule

`default_nettype wire

/* byte_link_if.sv */
`timescale 1ns/1ps
`default_nettype none

// byte handoff between the uart pair and the parser
interface byte_link_if;
    logic [7:0] rx_data;   // valid only with rx_valid
    logic       rx_valid;  // single cycle pulse, no back-pressure
    logic [7:0] tx_data;
    logic       tx_valid;  // accepted when tx_busy is low
    logic       tx_busy;

    modport rx_side (
        output rx_data, rx_valid
    );

    modport tx_side (
        input  tx_data, tx_valid,
        output tx_busy
    );

    modport parser (
        input  rx_data, rx_valid, tx_busy,
        output tx_data, tx_valid
    );
endinterface

`default_nettype wire

/* uart_cmd_pkg.sv */
`default_nettype none

package uart_cmd_pkg;

    // ========================================
    // serial timing
    // ========================================
    localparam int CLKS_PER_BIT    = 16;                  // 434 on the board for 115200 baud
    localparam int CNT_W           = $clog2(CLKS_PER_BIT);
    localparam int UART_FRAME_BITS = 10;                  // start, 8 data, stop

    // ========================================
    // frame layout and watchdog
    // ========================================
    localparam int FRAME_BYTES     = 8;
    localparam int BYTE_CNT_W      = $clog2(FRAME_BYTES);
    localparam int WATCHDOG_CYCLES = 40 * CLKS_PER_BIT;  // forty bit times of silence
    localparam int WD_W            = $clog2(WATCHDOG_CYCLES);

    // protocol codes
    localparam logic [7:0]  CMD_WRITE  = 8'h57;          // ascii W
    localparam logic [23:0] END_MARKER = 24'h454e44;     // ascii END
    localparam logic [7:0]  ACK_BYTE   = 8'h06;
    localparam logic [7:0]  NAK_BYTE   = 8'h15;

    // receiver fsm encoding
    localparam logic [1:0] RX_IDLE  = 2'd0;
    localparam logic [1:0] RX_START = 2'd1;
    localparam logic [1:0] RX_DATA  = 2'd2;
    localparam logic [1:0] RX_STOP  = 2'd3;

    // msb first on the wire, so cmd sits in the top byte
    typedef struct packed {
        logic [7:0]  cmd;
        logic [15:0] addr;
        logic [15:0] data;
        logic [23:0] trailer;
    } frame_fields_t;

    // same 64-bit word, field view for checks, byte view for shifting
    typedef union packed {
        frame_fields_t                   fields;
        logic [FRAME_BYTES-1:0][7:0]     bytes;
    } frame_u;

endpackage

`default_nettype wire
